// File: sim.f
hw/cpuPkg.sv
hw/pipeBarrier.sv
hw/instructionFetch.sv
hw/registerFile.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/dataMemory.sv
hw/cpu.sv
verification/cpu_assert.sv
verification/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module cpuTb -f sim.f -o cpuSim
./obj_dir/cpuSim

// File: verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

  localparam int clockPeriod = 4;
  localparam int resetCycles = 10;
  localparam int programLength = 10;
  localparam int timeoutNs = (resetCycles + programLength + 20) * clockPeriod;

  typedef struct packed {
    logic [31:0] word;
    logic writesBack;
    logic [4:0] index;
    logic [31:0] data;
  } stepT;

  logic clk;
  logic reset;
  logic imemWrite;
  logic [cpuPkg::imemIndexWidth-1:0] imemAddress;
  logic [31:0] imemData;
  logic wbValid;
  logic [4:0] wbIndex;
  logic [31:0] wbData;

  stepT steps [programLength];

  cpu UUT (
    .clk(clk),
    .reset(reset),
    .imemWrite(imemWrite),
    .imemAddress(imemAddress),
    .imemData(imemData),
    .wbValid(wbValid),
    .wbIndex(wbIndex),
    .wbData(wbData)
  );

  always #(clockPeriod / 2) clk = ~clk;

  // rv32i encodings
  function automatic logic [31:0] rType(input logic [6:0] funct7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] funct3,
                                        input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] funct3, input logic [4:0] rd,
                                        input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "value check failed");
    end
  endtask

  // expected results worked out by hand
  task automatic fillTable();
    steps[0] = {iType(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011), 1'b1, 5'd1, 32'h00000005};
    // x1 from memory stage, 5 - 8
    steps[1] = {iType(12'hff8, 5'd1, 3'b000, 5'd2, 7'b0010011), 1'b1, 5'd2, 32'hfffffffd};
    // x2 from memory stage, x1 from writeback
    steps[2] = {rType(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'h00000002};
    // x1 through the register file bypass
    steps[3] = {rType(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4), 1'b1, 5'd4, 32'hfffffffd};
    steps[4] = {rType(7'b0000000, 5'd2, 5'd4, 3'b111, 5'd5), 1'b1, 5'd5, 32'hfffffffd};
    steps[5] = {rType(7'b0000000, 5'd3, 5'd5, 3'b110, 5'd6), 1'b1, 5'd6, 32'hffffffff};
    // store data x6 forwarded
    steps[6] = {sType(12'd8, 5'd6, 5'd0), 1'b0, 5'd0, 32'h0};
    steps[7] = {iType(12'd7, 5'd0, 3'b000, 5'd0, 7'b0010011), 1'b0, 5'd0, 32'h0};
    steps[8] = {iType(12'd8, 5'd0, 3'b010, 5'd7, 7'b0000011), 1'b1, 5'd7, 32'hffffffff};
    // x0 must stay zero after the addi above
    steps[9] = {rType(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd8), 1'b1, 5'd8, 32'h00000005};
  endtask

  initial begin
    #(timeoutNs);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired before the program finished retiring");
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    imemWrite = 1'b0;
    imemAddress = '0;
    imemData = '0;
    fillTable();

    // program load while reset is held
    for (int c = 0; c < resetCycles; c++) begin
      @(negedge clk);
      if (c < programLength) begin
        imemWrite = 1'b1;
        imemAddress = cpuPkg::imemIndexWidth'(c);
        imemData = steps[c].word;
      end else begin
        imemWrite = 1'b0;
      end
    end
    @(negedge clk);
    imemWrite = 1'b0;
    reset = 1'b0;

    for (int i = 0; i < programLength; i++) begin
      if (steps[i].writesBack) begin
        @(negedge clk);
        while (!wbValid) begin
          @(negedge clk);
        end
        checkValue({27'd0, wbIndex}, {27'd0, steps[i].index},
                   $sformatf("wbIndex of step %0d", i));
        checkValue(wbData, steps[i].data, $sformatf("wbData of step %0d", i));
      end
    end

    // trailing zero words must not retire
    repeat (8) begin
      @(negedge clk);
      checkValue({31'd0, wbValid}, 32'd0, "writeback strobe after the last instruction");
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: verification/cpu_assert.sv
`timescale 1ns/1ps

module cpuAssert (
  input logic clk,
  input logic reset,
  input logic imemWrite,
  input logic wbValid,
  input logic [cpuPkg::regIndexWidth-1:0] wbIndex
);

  // barriers clear on the first reset edge
  property quietInReset;
    @(posedge clk) (reset && $past(reset)) |-> !wbValid;
  endproperty

  property noZeroIndex;
    @(posedge clk) wbValid |-> (wbIndex != '0);
  endproperty

  property loadOnlyInReset;
    @(posedge clk) imemWrite |-> reset;
  endproperty

  quietInResetCheck: assert property (quietInReset)
    else $error("writeback strobe seen while reset is held");
  noZeroIndexCheck: assert property (noZeroIndex)
    else $error("writeback strobe with destination x0");
  loadOnlyInResetCheck: assert property (loadOnlyInReset)
    else $error("instruction memory written outside reset");

endmodule

bind cpu cpuAssert checks (
  .clk(clk),
  .reset(reset),
  .imemWrite(imemWrite),
  .wbValid(wbValid),
  .wbIndex(wbIndex)
);

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic clk,
  input  logic reset,
  input  logic imemWrite,
  input  logic [cpuPkg::imemIndexWidth-1:0] imemAddress,
  input  logic [cpuPkg::xlen-1:0] imemData,
  output logic wbValid,
  output logic [cpuPkg::regIndexWidth-1:0] wbIndex,
  output logic [cpuPkg::xlen-1:0] wbData
);

  logic [cpuPkg::xlen-1:0] ifInstruction;
  logic ifValid;
  logic [cpuPkg::xlen-1:0] idInstruction;
  logic idValid;
  logic [cpuPkg::xlen-1:0] idLhsValue;
  logic [cpuPkg::xlen-1:0] idRhsValue;
  cpuPkg::idExT idDecoded;
  cpuPkg::idExT exStage;
  cpuPkg::exMemT exResult;
  cpuPkg::exMemT memStage;
  cpuPkg::memWbT memResult;
  cpuPkg::memWbT wbStage;
  logic [cpuPkg::xlen-1:0] memReadData;
  logic memRegWrite;
  logic [cpuPkg::xlen-1:0] writeBackData;

  instructionFetch fetch (
    .clk(clk),
    .reset(reset),
    .imemWrite(imemWrite),
    .imemAddress(imemAddress),
    .imemData(imemData),
    .instruction(ifInstruction),
    .fetchValid(ifValid)
  );

  // if/id barrier
  always_ff @(posedge clk) begin
    if (reset) begin
      idInstruction <= '0;
      idValid <= 1'b0;
    end else begin
      idInstruction <= ifInstruction;
      idValid <= ifValid;
    end
  end

  registerFile regs (
    .clk(clk),
    .reset(reset),
    .source1Index(idInstruction[19:15]),
    .source2Index(idInstruction[24:20]),
    .writeIndex(wbStage.writeIndex),
    .writeData(writeBackData),
    .shouldWrite(wbValid),
    .source1Data(idLhsValue),
    .source2Data(idRhsValue)
  );

  decodeUnit decode (
    .instruction(idInstruction),
    .fetchValid(idValid),
    .source1Data(idLhsValue),
    .source2Data(idRhsValue),
    .decoded(idDecoded)
  );

  pipeBarrier #(.payloadT(cpuPkg::idExT)) idExBarrier (
    .clk(clk),
    .reset(reset),
    .d(idDecoded),
    .q(exStage)
  );

  assign memRegWrite = memStage.valid && memStage.regWrite;

  executeUnit execute (
    .stage(exStage),
    .memWriteIndex(memStage.writeIndex),
    .memRegWrite(memRegWrite),
    .memAluResult(memStage.aluResult),
    .wbWriteIndex(wbStage.writeIndex),
    .wbRegWrite(wbValid),
    .wbData(writeBackData),
    .result(exResult)
  );

  pipeBarrier #(.payloadT(cpuPkg::exMemT)) exMemBarrier (
    .clk(clk),
    .reset(reset),
    .d(exResult),
    .q(memStage)
  );

  dataMemory dmem (
    .clk(clk),
    .reset(reset),
    .memWrite(memStage.memWrite && memStage.valid),
    .memRead(memStage.memRead && memStage.valid),
    .address(memStage.aluResult),
    .writeData(memStage.storeData),
    .readData(memReadData)
  );

  always_comb begin
    memResult.memoryData = memReadData;
    memResult.aluResult = memStage.aluResult;
    memResult.writeIndex = memStage.writeIndex;
    memResult.memToReg = memStage.memToReg;
    memResult.regWrite = memStage.regWrite;
    memResult.valid = memStage.valid;
  end

  pipeBarrier #(.payloadT(cpuPkg::memWbT)) memWbBarrier (
    .clk(clk),
    .reset(reset),
    .d(memResult),
    .q(wbStage)
  );

  // writeback mux
  assign writeBackData = wbStage.memToReg ? wbStage.memoryData : wbStage.aluResult;

  // x0 writes retire silently
  assign wbValid = wbStage.valid && wbStage.regWrite && (wbStage.writeIndex != '0);
  assign wbIndex = wbStage.writeIndex;
  assign wbData = writeBackData;

endmodule

// File: hw/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
  input  logic clk,
  input  logic reset,
  input  logic memWrite,
  input  logic memRead,
  input  logic [cpuPkg::xlen-1:0] address,
  input  logic [cpuPkg::xlen-1:0] writeData,
  output logic [cpuPkg::xlen-1:0] readData
);

  logic [cpuPkg::xlen-1:0] dmem [cpuPkg::dmemDepth];
  logic [cpuPkg::dmemIndexWidth-1:0] wordIndex;

  // word addressed, low two bits ignored
  assign wordIndex = address[cpuPkg::dmemIndexWidth+1:2];

  always_ff @(posedge clk) begin
    if (memWrite && !reset) begin
      dmem[wordIndex] <= writeData;
    end
  end

  assign readData = memRead ? dmem[wordIndex] : '0;

endmodule

// File: hw/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
  input  cpuPkg::idExT stage,
  input  logic [cpuPkg::regIndexWidth-1:0] memWriteIndex,
  input  logic memRegWrite,
  input  logic [cpuPkg::xlen-1:0] memAluResult,
  input  logic [cpuPkg::regIndexWidth-1:0] wbWriteIndex,
  input  logic wbRegWrite,
  input  logic [cpuPkg::xlen-1:0] wbData,
  output cpuPkg::exMemT result
);

  cpuPkg::forwardSelT lhsSelect;
  cpuPkg::forwardSelT rhsSelect;
  logic [cpuPkg::xlen-1:0] lhsForwarded;
  logic [cpuPkg::xlen-1:0] rhsForwarded;
  logic [cpuPkg::xlen-1:0] operand2;
  logic [3:0] aluControl;
  logic [cpuPkg::xlen-1:0] aluResult;

  // memory stage is younger, so it wins over writeback
  function automatic cpuPkg::forwardSelT selectSource(
    input logic [cpuPkg::regIndexWidth-1:0] readIndex
  );
    if (memRegWrite && memWriteIndex != '0 && memWriteIndex == readIndex) begin
      return cpuPkg::fwdMem;
    end
    if (wbRegWrite && wbWriteIndex != '0 && wbWriteIndex == readIndex) begin
      return cpuPkg::fwdWb;
    end
    return cpuPkg::fwdNone;
  endfunction

  always_comb begin
    lhsSelect = selectSource(stage.lhsIndex);
    rhsSelect = selectSource(stage.rhsIndex);
    case (lhsSelect)
      cpuPkg::fwdMem: lhsForwarded = memAluResult;
      cpuPkg::fwdWb: lhsForwarded = wbData;
      default: lhsForwarded = stage.lhsValue;
    endcase
    case (rhsSelect)
      cpuPkg::fwdMem: rhsForwarded = memAluResult;
      cpuPkg::fwdWb: rhsForwarded = wbData;
      default: rhsForwarded = stage.rhsValue;
    endcase
  end

  assign operand2 = stage.aluSrc ? stage.immediate : rhsForwarded;

  always_comb begin
    aluControl = cpuPkg::aluAdd;
    if (stage.aluOp != cpuPkg::aluOpMem) begin
      case (stage.funct3)
        3'b111: aluControl = cpuPkg::aluAnd;
        3'b110: aluControl = cpuPkg::aluOr;
        default: begin
          // funct7[5] marks sub, only meaningful for r-type
          if (stage.aluOp == cpuPkg::aluOpR && stage.funct7[5]) aluControl = cpuPkg::aluSub;
        end
      endcase
    end
  end

  always_comb begin
    case (aluControl)
      cpuPkg::aluAnd: aluResult = lhsForwarded & operand2;
      cpuPkg::aluOr: aluResult = lhsForwarded | operand2;
      cpuPkg::aluSub: aluResult = lhsForwarded - operand2;
      default: aluResult = lhsForwarded + operand2;
    endcase
  end

  always_comb begin
    result.aluResult = aluResult;
    result.storeData = rhsForwarded;
    result.writeIndex = stage.writeIndex;
    result.memRead = stage.memRead;
    result.memWrite = stage.memWrite;
    result.memToReg = stage.memToReg;
    result.regWrite = stage.regWrite;
    result.valid = stage.valid;
  end

endmodule

// File: hw/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
  input  logic [cpuPkg::xlen-1:0] instruction,
  input  logic fetchValid,
  input  logic [cpuPkg::xlen-1:0] source1Data,
  input  logic [cpuPkg::xlen-1:0] source2Data,
  output cpuPkg::idExT decoded
);

  logic [6:0] opcode;
  logic knownOpcode;
  logic [cpuPkg::xlen-1:0] immI;
  logic [cpuPkg::xlen-1:0] immS;

  assign opcode = instruction[6:0];
  assign immI = {{20{instruction[31]}}, instruction[31:20]};
  assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};

  always_comb begin
    decoded = '0;
    knownOpcode = 1'b1;
    decoded.lhsValue = source1Data;
    decoded.rhsValue = source2Data;
    decoded.lhsIndex = instruction[19:15];
    decoded.rhsIndex = instruction[24:20];
    decoded.writeIndex = instruction[11:7];
    decoded.funct3 = instruction[14:12];
    decoded.funct7 = instruction[31:25];
    decoded.immediate = (opcode == cpuPkg::opStore) ? immS : immI;

    case (opcode)
      cpuPkg::opR: begin
        decoded.aluOp = cpuPkg::aluOpR;
        decoded.regWrite = 1'b1;
      end
      cpuPkg::opImm: begin
        decoded.aluOp = cpuPkg::aluOpImm;
        decoded.aluSrc = 1'b1;
        decoded.regWrite = 1'b1;
      end
      cpuPkg::opLoad: begin
        decoded.aluOp = cpuPkg::aluOpMem;
        decoded.aluSrc = 1'b1;
        decoded.memRead = 1'b1;
        decoded.memToReg = 1'b1;
        decoded.regWrite = 1'b1;
      end
      cpuPkg::opStore: begin
        decoded.aluOp = cpuPkg::aluOpMem;
        decoded.aluSrc = 1'b1;
        decoded.memWrite = 1'b1;
      end
      default: knownOpcode = 1'b0;
    endcase

    // zero words and bubbles carry no side effects
    decoded.valid = knownOpcode && fetchValid;
    if (!decoded.valid) begin
      decoded.memRead = 1'b0;
      decoded.memWrite = 1'b0;
      decoded.memToReg = 1'b0;
      decoded.regWrite = 1'b0;
    end
  end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic clk,
  input  logic reset,
  input  logic [cpuPkg::regIndexWidth-1:0] source1Index,
  input  logic [cpuPkg::regIndexWidth-1:0] source2Index,
  input  logic [cpuPkg::regIndexWidth-1:0] writeIndex,
  input  logic [cpuPkg::xlen-1:0] writeData,
  input  logic shouldWrite,
  output logic [cpuPkg::xlen-1:0] source1Data,
  output logic [cpuPkg::xlen-1:0] source2Data
);

  logic [cpuPkg::xlen-1:0] registers [32];
  logic writeEnable;

  assign writeEnable = shouldWrite && (writeIndex != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        registers[i] <= '0;
      end
    end else if (writeEnable) begin
      registers[writeIndex] <= writeData;
    end
  end

  // write-through so decode sees the value retiring this cycle
  always_comb begin
    source1Data = registers[source1Index];
    source2Data = registers[source2Index];
    if (writeEnable && writeIndex == source1Index) source1Data = writeData;
    if (writeEnable && writeIndex == source2Index) source2Data = writeData;
    if (source1Index == '0) source1Data = '0;
    if (source2Index == '0) source2Data = '0;
  end

endmodule

// File: hw/instructionFetch.sv
`timescale 1ns/1ps

module instructionFetch (
  input  logic clk,
  input  logic reset,
  input  logic imemWrite,
  input  logic [cpuPkg::imemIndexWidth-1:0] imemAddress,
  input  logic [cpuPkg::xlen-1:0] imemData,
  output logic [cpuPkg::xlen-1:0] instruction,
  output logic fetchValid
);

  logic [cpuPkg::xlen-1:0] imem [cpuPkg::imemDepth];
  logic [cpuPkg::xlen-1:0] programCounter;
  logic [cpuPkg::imemIndexWidth-1:0] fetchIndex;

  // unloaded words read as zero and decode as invalid
  initial begin
    for (int i = 0; i < cpuPkg::imemDepth; i++) begin
      imem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (imemWrite) begin
      imem[imemAddress] <= imemData;
    end
  end

  assign fetchIndex = programCounter[cpuPkg::imemIndexWidth+1:2];
  assign fetchValid = programCounter < cpuPkg::xlen'(cpuPkg::imemDepth * 4);
  assign instruction = imem[fetchIndex];

  // pc parks one word past the end of memory
  always_ff @(posedge clk) begin
    if (reset) begin
      programCounter <= '0;
    end else if (fetchValid) begin
      programCounter <= programCounter + cpuPkg::xlen'(4);
    end
  end

endmodule

// File: hw/pipeBarrier.sv
`timescale 1ns/1ps

module pipeBarrier #(
  parameter type payloadT = logic
) (
  input  logic clk,
  input  logic reset,
  input  payloadT d,
  output payloadT q
);

  // all-zero payload is a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

// File: hw/cpuPkg.sv
package cpuPkg;

  localparam int xlen = 32;
  localparam int regIndexWidth = 5;
  localparam int imemDepth = 64;
  localparam int imemIndexWidth = $clog2(imemDepth);
  localparam int dmemDepth = 256;
  localparam int dmemIndexWidth = $clog2(dmemDepth);

  // rv32i major opcodes
  localparam logic [6:0] opR = 7'b0110011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  localparam logic [3:0] aluAnd = 4'b0000;
  localparam logic [3:0] aluOr = 4'b0001;
  localparam logic [3:0] aluAdd = 4'b0010;
  localparam logic [3:0] aluSub = 4'b0110;

  // alu operation class from main control
  localparam logic [1:0] aluOpMem = 2'b00;
  localparam logic [1:0] aluOpR = 2'b10;
  localparam logic [1:0] aluOpImm = 2'b11;

  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb = 2'b01,
    fwdMem = 2'b10
  } forwardSelT;

  typedef struct packed {
    logic [xlen-1:0] lhsValue;
    logic [xlen-1:0] rhsValue;
    logic [regIndexWidth-1:0] lhsIndex;
    logic [regIndexWidth-1:0] rhsIndex;
    logic [regIndexWidth-1:0] writeIndex;
    logic [xlen-1:0] immediate;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [1:0] aluOp;
    logic aluSrc;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic valid;
  } idExT;

  typedef struct packed {
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] storeData;
    logic [regIndexWidth-1:0] writeIndex;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic valid;
  } exMemT;

  typedef struct packed {
    logic [xlen-1:0] memoryData;
    logic [xlen-1:0] aluResult;
    logic [regIndexWidth-1:0] writeIndex;
    logic memToReg;
    logic regWrite;
    logic valid;
  } memWbT;

endpackage
